// ==== source/proc_pkg.sv ====
package proc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [3:0]  byte_en_t;

    localparam int REG_COUNT = 32;

    // Instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int RD_HI     = 25;
    localparam int RD_LO     = 21;
    localparam int RS1_HI    = 20;
    localparam int RS1_LO    = 16;
    localparam int RS2_HI    = 15;
    localparam int RS2_LO    = 11;
    localparam int IMM_HI    = 15;
    localparam int IMM_LO    = 0;

    // Cache geometry, one word per line
    localparam int CACHE_LINES      = 16;
    localparam int CACHE_INDEX_BITS = $clog2(CACHE_LINES);
    localparam int CACHE_TAG_BITS   = 32 - CACHE_INDEX_BITS - 2;

    // Backing memory
    localparam int MEM_WORDS     = 1024;
    localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY   = 4;
    localparam int MEM_CNT_BITS  = $clog2(MEM_LATENCY) + 1;

    typedef logic [CACHE_INDEX_BITS-1:0] cache_index_t;
    typedef logic [CACHE_TAG_BITS-1:0]   cache_tag_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and pipeline records
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        op_nop  = 6'h00,
        op_add  = 6'h01,
        op_sub  = 6'h02,
        op_and  = 6'h03,
        op_or   = 6'h04,
        op_xor  = 6'h05,
        op_slt  = 6'h06,
        op_addi = 6'h07,
        op_lw   = 6'h08,
        op_sw   = 6'h09,
        op_lb   = 6'h0a,
        op_sb   = 6'h0b
    } opcode_t;

    // Control flags, is_load steers write-back to the cache data
    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic byte_sel;
        logic reg_write;
        logic is_load;
    } control_t;

    typedef struct packed {
        logic       valid;
        opcode_t    op;
        control_t   control;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        logic       use_imm;
        reg_index_t rd;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        reg_index_t rd;
        word_t      data;
    } wb_t;

    typedef enum logic [1:0] {
        cache_idle,
        cache_fill,
        cache_write
    } cache_state_t;

endpackage

// ==== source/decode.sv ====
`timescale 1ns/1ps

module decode import proc_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  word_t  ir,
    input  logic   hold,
    input  wb_t    wb,
    output id_ex_t id_ex
);

    // Raw fields
    opcode_t    op;
    reg_index_t rd;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rs2_sel;
    word_t      imm;

    // Decoded controls
    control_t control;
    logic     use_imm;
    logic     valid;

    // Register file
    word_t regs [REG_COUNT];
    word_t rs1_data;
    word_t rs2_data;

    assign op  = opcode_t'(ir[OPCODE_HI:OPCODE_LO]);
    assign rd  = ir[RD_HI:RD_LO];
    assign rs1 = ir[RS1_HI:RS1_LO];
    assign rs2 = ir[RS2_HI:RS2_LO];
    // Sign extension of the 16-bit immediate
    assign imm = {{16{ir[IMM_HI]}}, ir[IMM_HI:IMM_LO]};

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        control = '0;
        use_imm = 1'b0;
        valid   = 1'b1;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
                control.reg_write = 1'b1;
            end
            op_addi: begin
                control.reg_write = 1'b1;
                use_imm           = 1'b1;
            end
            op_lw, op_lb: begin
                control.mem_read  = 1'b1;
                control.reg_write = 1'b1;
                control.is_load   = 1'b1;
                control.byte_sel  = (op == op_lb);
                use_imm           = 1'b1;
            end
            op_sw, op_sb: begin
                control.mem_write = 1'b1;
                control.byte_sel  = (op == op_sb);
                use_imm           = 1'b1;
            end
            // Nop and unknown codes leave the slot empty
            default: begin
                valid = 1'b0;
            end
        endcase
    end

    // Store data register sits in the rd field, the rs2 bits belong to the offset
    assign rs2_sel = control.mem_write ? rd : rs2;

    // Register 0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    // Register write from the registered write-back port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register, frozen during a stall
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid   <= 1'b0;
            id_ex.control <= '0;
        end else if (!hold) begin
            id_ex.valid    <= valid;
            id_ex.op       <= op;
            id_ex.control  <= control;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.use_imm  <= use_imm;
            id_ex.rd       <= rd;
        end
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import proc_pkg::*; (
    input  id_ex_t id_ex,
    output word_t  result
);

    word_t operand_a;
    word_t operand_b;

    // First operand always from rs1
    assign operand_a = id_ex.rs1_data;
    // Immediate replaces rs2 for addi
    assign operand_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_data;

    always_comb begin
        case (id_ex.op)
            op_add, op_addi: begin
                result = operand_a + operand_b;
            end
            op_sub: begin
                result = operand_a - operand_b;
            end
            op_and: begin
                result = operand_a & operand_b;
            end
            op_or: begin
                result = operand_a | operand_b;
            end
            op_xor: begin
                result = operand_a ^ operand_b;
            end
            // Signed compare, result is 0 or 1
            op_slt: begin
                result = ($signed(operand_a) < $signed(operand_b)) ? 32'd1 : 32'd0;
            end
            // Memory ops and nop, result unused by write-back
            default: begin
                result = operand_a + operand_b;
            end
        endcase
    end

endmodule

// ==== source/data_cache.sv ====
`timescale 1ns/1ps

module data_cache import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  id_ex_t   id_ex,
    input  word_t    mem_rdata,
    input  logic     mem_ready,
    output word_t    load_data,
    output logic     stall,
    output logic     mem_read,
    output logic     mem_write,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output byte_en_t mem_byte_en
);

    cache_state_t state;
    cache_state_t state_next;

    // Line storage
    logic       line_valid [CACHE_LINES];
    cache_tag_t line_tag [CACHE_LINES];
    word_t      line_data [CACHE_LINES];

    // Address split
    word_t        addr;
    logic [1:0]   lane;
    cache_index_t index;
    cache_tag_t   tag;

    logic       hit;
    logic       is_load;
    logic       is_store;
    word_t      word_src;
    logic [7:0] byte_src;
    byte_en_t   byte_en;
    word_t      store_data;

    // Own adder for the effective address
    assign addr  = id_ex.rs1_data + id_ex.imm;
    assign lane  = addr[1:0];
    assign index = addr[CACHE_INDEX_BITS+1:2];
    assign tag   = addr[31:CACHE_INDEX_BITS+2];

    assign hit      = line_valid[index] && (line_tag[index] == tag);
    assign is_load  = id_ex.valid && id_ex.control.mem_read;
    assign is_store = id_ex.valid && id_ex.control.mem_write;

    // Fill data bypasses the line on the ready cycle
    assign word_src  = (state == cache_fill) ? mem_rdata : line_data[index];
    assign byte_src  = word_src[8*lane +: 8];
    assign load_data = id_ex.control.byte_sel ? {24'b0, byte_src} : word_src;

    // Byte stores replicate the low byte on all lanes
    always_comb begin
        if (id_ex.control.byte_sel) begin
            byte_en    = 4'b0001 << lane;
            store_data = {4{id_ex.rs2_data[7:0]}};
        end else begin
            byte_en    = 4'b1111;
            store_data = id_ex.rs2_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Miss FSM and stall
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        stall      = 1'b0;
        case (state)
            cache_idle: begin
                if (is_store) begin
                    state_next = cache_write;
                    stall      = 1'b1;
                end else if (is_load && !hit) begin
                    state_next = cache_fill;
                    stall      = 1'b1;
                end
            end
            // Release on the ready pulse
            cache_fill, cache_write: begin
                stall = !mem_ready;
                if (mem_ready) begin
                    state_next = cache_idle;
                end
            end
            default: begin
                state_next = cache_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cache_idle;
        end else begin
            state <= state_next;
        end
    end

    // Request levels, word aligned
    assign mem_read    = (state == cache_fill);
    assign mem_write   = (state == cache_write);
    assign mem_addr    = {addr[31:2], 2'b00};
    assign mem_wdata   = store_data;
    assign mem_byte_en = byte_en;

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < CACHE_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (state == cache_fill && mem_ready) begin
            line_valid[index] <= 1'b1;
        end
    end

    // Line fill, or merge of a store hit; store misses allocate nothing
    always_ff @(posedge clk) begin
        if (state == cache_fill && mem_ready) begin
            line_tag[index]  <= tag;
            line_data[index] <= mem_rdata;
        end else if (state == cache_write && mem_ready && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    line_data[index][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== source/main_mem.sv ====
`timescale 1ns/1ps

module main_mem import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     read,
    input  logic     write,
    input  word_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    output word_t    rdata,
    output logic     ready
);

    word_t                    mem [MEM_WORDS];
    logic [MEM_ADDR_BITS-1:0] word_index;
    logic [MEM_CNT_BITS-1:0]  count;
    logic                     last_cycle;

    // Upper address bits fold onto the array
    assign word_index = addr[MEM_ADDR_BITS+1:2];
    assign last_cycle = (count == MEM_CNT_BITS'(MEM_LATENCY - 1));

    // Latency counter, ready one cycle wide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            ready <= 1'b0;
        end else if (ready) begin
            count <= '0;
            ready <= 1'b0;
        end else if (read || write) begin
            if (last_cycle) begin
                ready <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Read word presented with ready
    always_ff @(posedge clk) begin
        if (read && !ready && last_cycle) begin
            rdata <= mem[word_index];
        end
    end

    // Byte-enabled write at the end of the ready cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ready && write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== source/writeback.sv ====
`timescale 1ns/1ps

module writeback import proc_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   hold,
    input  id_ex_t id_ex,
    input  word_t  alu_result,
    input  word_t  load_data,
    output wb_t    wb
);

    logic  wb_valid;
    word_t wb_data;

    // Register 0 writes never reach the trace
    assign wb_valid = id_ex.valid && id_ex.control.reg_write && (id_ex.rd != '0);

    // Loads take the cache word
    assign wb_data = id_ex.control.is_load ? load_data : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else if (!hold) begin
            wb.valid <= wb_valid;
            wb.rd    <= id_ex.rd;
            wb.data  <= wb_data;
        end
    end

endmodule

// ==== source/proc.sv ====
`timescale 1ns/1ps

module proc import proc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t ir,
    output logic  stall,
    output wb_t   wb,
    output logic  mem_read,
    output logic  mem_write,
    output word_t mem_addr
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////////////////////

    // Decoded instruction shared by ALU and cache
    id_ex_t id_ex;

    word_t alu_result;
    word_t load_data;

    // Cache to memory levels
    word_t    mem_wdata;
    word_t    mem_rdata;
    byte_en_t mem_byte_en;
    logic     mem_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////

    // Stall freezes both pipeline registers
    decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .ir    (ir),
        .hold  (stall),
        .wb    (wb),
        .id_ex (id_ex)
    );

    alu u_alu (
        .id_ex  (id_ex),
        .result (alu_result)
    );

    data_cache u_data_cache (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_ex       (id_ex),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .load_data   (load_data),
        .stall       (stall),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en)
    );

    main_mem u_main_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .read    (mem_read),
        .write   (mem_write),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .byte_en (mem_byte_en),
        .rdata   (mem_rdata),
        .ready   (mem_ready)
    );

    // Result select and trace register
    writeback u_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .hold       (stall),
        .id_ex      (id_ex),
        .alu_result (alu_result),
        .load_data  (load_data),
        .wb         (wb)
    );

endmodule

// ==== verification/proc_tb.sv ====
`timescale 1ns/1ps

module proc_tb import proc_pkg::*; ();

    localparam int    WAIT_LIMIT = 200;
    localparam word_t NOP        = 32'h0000_0000;

    logic  clk;
    logic  rst_n;
    word_t ir;
    logic  stall;
    wb_t   wb;
    logic  mem_read;
    logic  mem_write;
    word_t mem_addr;

    // Reference register file and byte memory, 4 KiB as the DUT folds it
    word_t      model_regs [REG_COUNT];
    logic [7:0] model_mem [4096];
    wb_t        trace_q [$];
    wb_t        expect_q [$];

    integer seed;
    int     error_count;
    int     tests_passed;
    int     tests_failed;
    int     read_cycles;
    int     write_cycles;
    int     stall_cycles;
    word_t  read_addr;
    word_t  write_addr;
    logic   wb_loaded;
    logic   timed_out;

    proc uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ir        (ir),
        .stall     (stall),
        .wb        (wb),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Trace monitor, sampled at the falling edge
    ////////////////////////////////////////////////////////////////////////////

    // wb only moves on an edge where stall was low
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_loaded && wb.valid) begin
                trace_q.push_back(wb);
            end
            if (mem_read) begin
                read_cycles++;
                read_addr = mem_addr;
            end
            if (mem_write) begin
                write_cycles++;
                write_addr = mem_addr;
            end
            if (stall) begin
                stall_cycles++;
            end
            wb_loaded = !stall;
        end else begin
            wb_loaded = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoding, drive and compare helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t encode_reg(opcode_t op, reg_index_t rd, reg_index_t rs1,
                                         reg_index_t rs2);
        return {op, rd, rs1, rs2, 11'b0};
    endfunction

    function automatic word_t encode_imm(opcode_t op, reg_index_t rd, reg_index_t rs1,
                                         logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic logic [15:0] rand16();
        word_t r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Called 5 ns after a rising edge; holds ir until the core takes it
    task automatic issue(input word_t instr);
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (stall && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (stall) begin
            $display("Timeout at %0t ns: stall stayed high for %0d cycles", $time, WAIT_LIMIT);
            timed_out = 1'b1;
            error_count++;
            return;
        end
        ir = instr;
        @(posedge clk);
        #5;
        ir = NOP;
    endtask

    task automatic issue_gap();
        repeat (3) begin
            issue(NOP);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic next_entry(output wb_t entry, output logic found);
        int waited;
        found = 1'b0;
        entry = '0;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (trace_q.size() == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (trace_q.size() == 0) begin
            $display("Timeout at %0t ns: no write-back entry within %0d cycles",
                     $time, WAIT_LIMIT);
            timed_out = 1'b1;
            error_count++;
        end else begin
            entry = trace_q.pop_front();
            found = 1'b1;
        end
    endtask

    // Pops one trace entry per expected result, in issue order
    task automatic drain();
        wb_t  got;
        wb_t  want;
        logic found;
        while (expect_q.size() != 0 && !timed_out) begin
            want = expect_q.pop_front();
            next_entry(got, found);
            if (found) begin
                check_word("wb.rd", word_t'(got.rd), word_t'(want.rd));
                check_word("wb.data", got.data, want.data);
            end
        end
        if (trace_q.size() != 0) begin
            $display("Fail at %0t ns: %0d write-back entries nobody expected",
                     $time, trace_q.size());
            error_count++;
            trace_q.delete();
        end
        expect_q.delete();
    endtask

    // Reference model step, then the instruction goes to the core
    task automatic execute(input opcode_t op, input reg_index_t rd, input reg_index_t rs1,
                           input reg_index_t rs2, input logic [15:0] imm);
        word_t       a;
        word_t       b;
        word_t       imm_ext;
        word_t       result;
        logic [11:0] byte_addr;
        logic [11:0] word_base;
        logic        writes;
        logic        reg_form;
        wb_t         entry;
        a         = model_regs[rs1];
        b         = model_regs[rs2];
        imm_ext   = {{16{imm[15]}}, imm};
        byte_addr = 12'(a + imm_ext);
        word_base = {byte_addr[11:2], 2'b00};
        result    = '0;
        writes    = 1'b1;
        reg_form  = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
                reg_form = 1'b1;
                case (op)
                    op_add: result = a + b;
                    op_sub: result = a - b;
                    op_and: result = a & b;
                    op_or: result = a | b;
                    op_xor: result = a ^ b;
                    default: begin
                        // Differing signs decide alone, else plain magnitude
                        if (a[31] != b[31]) begin
                            result = {31'b0, a[31]};
                        end else begin
                            result = {31'b0, (a < b)};
                        end
                    end
                endcase
            end
            op_addi: result = a + imm_ext;
            op_lw: begin
                result = {model_mem[word_base + 3], model_mem[word_base + 2],
                          model_mem[word_base + 1], model_mem[word_base]};
            end
            op_lb: result = {24'b0, model_mem[byte_addr]};
            // Store data comes from the register in the rd field
            op_sw: begin
                writes = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    model_mem[word_base + i] = model_regs[rd][8*i +: 8];
                end
            end
            op_sb: begin
                writes = 1'b0;
                model_mem[byte_addr] = model_regs[rd][7:0];
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != '0) begin
            entry.valid = 1'b1;
            entry.rd    = rd;
            entry.data  = result;
            expect_q.push_back(entry);
            model_regs[rd] = result;
        end
        if (reg_form) begin
            issue(encode_reg(op, rd, rs1, rs2));
        end else begin
            issue(encode_imm(op, rd, rs1, imm));
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_arith();
        int errors_before;
        errors_before = error_count;
        execute(op_addi, 5'd1, 5'd0, 5'd0, rand16());
        execute(op_addi, 5'd2, 5'd0, 5'd0, rand16());
        issue_gap();
        execute(op_add, 5'd3, 5'd1, 5'd2, 16'h0);
        execute(op_sub, 5'd4, 5'd1, 5'd2, 16'h0);
        execute(op_and, 5'd5, 5'd1, 5'd2, 16'h0);
        execute(op_or, 5'd6, 5'd1, 5'd2, 16'h0);
        // Target r0, must stay out of the trace
        execute(op_add, 5'd0, 5'd1, 5'd2, 16'h0);
        execute(op_xor, 5'd7, 5'd1, 5'd2, 16'h0);
        execute(op_slt, 5'd8, 5'd1, 5'd2, 16'h0);
        execute(op_slt, 5'd9, 5'd2, 5'd1, 16'h0);
        issue_gap();
        drain();
        report_test("run_arith", errors_before);
    endtask

    task automatic run_immediate();
        int errors_before;
        errors_before = error_count;
        // Sign bit forced so the upper half reads all ones
        execute(op_addi, 5'd13, 5'd0, 5'd0, rand16() | 16'h8000);
        issue_gap();
        execute(op_addi, 5'd14, 5'd13, 5'd0, rand16() & 16'h7fff);
        issue_gap();
        drain();
        report_test("run_immediate", errors_before);
    endtask

    task automatic run_store_load();
        int errors_before;
        errors_before = error_count;
        execute(op_addi, 5'd10, 5'd0, 5'd0, 16'h0200);
        execute(op_addi, 5'd11, 5'd0, 5'd0, rand16());
        issue_gap();
        write_cycles = 0;
        stall_cycles = 0;
        write_addr   = '0;
        execute(op_sw, 5'd11, 5'd10, 5'd0, 16'h0010);
        // Following slot waits out the write-through
        issue(NOP);
        if (write_cycles == 0) begin
            $display("Fail at %0t ns: mem_write never went high during the store", $time);
            error_count++;
        end
        // Base 0x200 plus offset 0x10, already word aligned
        check_word("mem_addr", write_addr, 32'h0000_0210);
        if (stall_cycles != MEM_LATENCY + 1) begin
            $display("Fail at %0t ns: stall high for %0d cycles, expected %0d",
                     $time, stall_cycles, MEM_LATENCY + 1);
            error_count++;
        end
        execute(op_lw, 5'd12, 5'd10, 5'd0, 16'h0010);
        issue_gap();
        drain();
        report_test("run_store_load", errors_before);
    endtask

    task automatic run_cache_hit();
        int errors_before;
        errors_before = error_count;
        execute(op_addi, 5'd20, 5'd0, 5'd0, rand16());
        issue_gap();
        execute(op_sw, 5'd20, 5'd0, 5'd0, 16'h0480);
        execute(op_lw, 5'd21, 5'd0, 5'd0, 16'h0480);
        drain();
        // Line now valid, second load must not touch memory
        read_cycles = 0;
        execute(op_lw, 5'd22, 5'd0, 5'd0, 16'h0480);
        drain();
        if (read_cycles != 0) begin
            $display("Fail at %0t ns: mem_read high for %0d cycles, expected 0",
                     $time, read_cycles);
            error_count++;
        end
        // Same index, other tag
        execute(op_addi, 5'd23, 5'd0, 5'd0, rand16());
        issue_gap();
        execute(op_sw, 5'd23, 5'd0, 5'd0, 16'h04c0);
        execute(op_lw, 5'd24, 5'd0, 5'd0, 16'h04c0);
        drain();
        read_cycles = 0;
        read_addr   = '0;
        execute(op_lw, 5'd25, 5'd0, 5'd0, 16'h0480);
        drain();
        if (read_cycles == 0) begin
            $display("Fail at %0t ns: reload after eviction never raised mem_read", $time);
            error_count++;
        end
        check_word("mem_addr", read_addr, 32'h0000_0480);
        report_test("run_cache_hit", errors_before);
    endtask

    task automatic run_byte_ops();
        int          errors_before;
        logic [15:0] r;
        logic [15:0] byte_offset;
        errors_before = error_count;
        r = rand16();
        byte_offset = 16'h0300 + {14'b0, r[1:0]};
        execute(op_addi, 5'd16, 5'd0, 5'd0, rand16());
        execute(op_addi, 5'd17, 5'd0, 5'd0, rand16());
        issue_gap();
        execute(op_sw, 5'd16, 5'd0, 5'd0, 16'h0300);
        // Miss fills the line so the byte store below hits
        execute(op_lw, 5'd18, 5'd0, 5'd0, 16'h0300);
        execute(op_sb, 5'd17, 5'd0, 5'd0, byte_offset);
        // Hit, word comes from the line with the one lane merged
        execute(op_lw, 5'd26, 5'd0, 5'd0, 16'h0300);
        issue_gap();
        execute(op_lb, 5'd19, 5'd0, 5'd0, byte_offset);
        issue_gap();
        drain();
        report_test("run_byte_ops", errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed         = 32'h512a;
        clk          = 1'b0;
        rst_n        = 1'b0;
        ir           = NOP;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        read_cycles  = 0;
        write_cycles = 0;
        stall_cycles = 0;
        read_addr    = '0;
        write_addr   = '0;
        wb_loaded    = 1'b0;
        timed_out    = 1'b0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 4096; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        run_arith();
        run_immediate();
        run_store_load();
        run_cache_hit();
        run_byte_ops();
        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/proc_pkg.sv
source/decode.sv
source/alu.sv
source/data_cache.sv
source/main_mem.sv
source/writeback.sv
source/proc.sv
verification/proc_tb.sv

// ==== Bender.yml ====
package:
  name: proc

sources:
  - files:
      - source/proc_pkg.sv
      - source/decode.sv
      - source/alu.sv
      - source/data_cache.sv
      - source/main_mem.sv
      - source/writeback.sv
      - source/proc.sv
  - target: test
    files:
      - verification/proc_tb.sv
